// File: Makefile
# Verilator flow for the NoC to AXIS link

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module noc_axis_link_top -f build.f

sim:
	verilator --binary --timing --assert --top-module noc_axis_link_tb -f build.f \
		-Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
source/noc_bridge_pkg.sv
source/axis_lane_if.sv
source/noc_axis_bridge.sv
source/axis_link_split.sv
source/axis_link_merge.sv
source/noc_axis_link_top.sv
dv/noc_axis_link_tb.sv

// File: dv/noc_axis_link_tb.sv
// Table-driven testbench for the NoC to AXIS link with a per-link, per-channel scoreboard

`timescale 1ns/10ps

module noc_axis_link_tb;

  localparam int NumLinks   = 4;
  localparam int NumStreams = 3 * NumLinks;
  localparam int NumRows    = 12;
  localparam int BurstLen   = 3;
  localparam int StallLen   = 6;
  localparam int CycleLimit = 50 * NumRows + 200;

  // Row kinds whose first three double as channel index
  localparam int KindReq    = 0;
  localparam int KindRsp    = 1;
  localparam int KindWide   = 2;
  localparam int KindInReq  = 3;
  localparam int KindInRsp  = 4;
  localparam int KindInWide = 5;
  localparam int KindBurst  = 6;

  logic                                        clk;
  logic                                        arst_n;
  logic [NumLinks-1:0]                         narrow_req_valid_i, narrow_req_ready_o;
  logic [NumLinks-1:0]                         narrow_rsp_valid_i, narrow_rsp_ready_o;
  logic [NumLinks-1:0]                         wide_valid_i, wide_ready_o;
  noc_bridge_pkg::narrow_data_t [NumLinks-1:0] narrow_req_data_i, narrow_rsp_data_i;
  noc_bridge_pkg::wide_data_t [NumLinks-1:0]   wide_data_i;
  logic [NumLinks-1:0]                         narrow_req_valid_o, narrow_req_ready_i;
  logic [NumLinks-1:0]                         narrow_rsp_valid_o, narrow_rsp_ready_i;
  logic [NumLinks-1:0]                         wide_valid_o, wide_ready_i;
  noc_bridge_pkg::narrow_data_t [NumLinks-1:0] narrow_req_data_o, narrow_rsp_data_o;
  noc_bridge_pkg::wide_data_t [NumLinks-1:0]   wide_data_o;
  logic                                        axis_out_valid_o, axis_out_ready_i;
  noc_bridge_pkg::axis_data_t                  axis_out_data_o;
  noc_bridge_pkg::axis_strb_t                  axis_out_strb_o;
  noc_bridge_pkg::link_id_t                    axis_out_dest_o;
  logic                                        axis_in_valid_i, axis_in_ready_o;
  noc_bridge_pkg::axis_data_t                  axis_in_data_i;
  noc_bridge_pkg::link_id_t                    axis_in_dest_i;

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  string row_name [NumRows] = '{
    "req_link0", "rsp_link1", "wide_link2", "req_link3", "in_req_link1", "in_rsp_link2",
    "in_wide_link3", "in_wide_stall_link0", "in_req_stall_link2", "burst_all",
    "burst_all_stall", "wide_stall_link1"
  };
  int row_link [NumRows] = '{0, 1, 2, 3, 1, 2, 3, 0, 2, 0, 0, 1};
  int row_kind [NumRows] = '{
    KindReq, KindRsp, KindWide, KindReq, KindInReq, KindInRsp,
    KindInWide, KindInWide, KindInReq, KindBurst, KindBurst, KindWide
  };
  noc_bridge_pkg::wide_data_t row_data [NumRows] = '{
    64'h0000_0000_1234_5678, 64'h0000_0000_9ABC_DEF0, 64'hFEDC_BA98_7654_3210,
    64'h0000_0000_0BAD_F00D, 64'hAAAA_5555_C0DE_0001, 64'h5555_AAAA_C0DE_0002,
    64'h0123_4567_89AB_CDEF, 64'h1122_3344_5566_7788, 64'hDEAD_BEEF_0000_0042,
    64'h0, 64'h0, 64'h8877_6655_4433_2211
  };
  bit row_stall [NumRows] = '{0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 1, 1};

  // Scoreboard with one queue per link and channel
  noc_bridge_pkg::axis_data_t exp_q [NumStreams][$];
  noc_bridge_pkg::wide_data_t cur_data [NumStreams];
  int                         pending [NumStreams];
  int                         sent_count  = 0;
  int                         recv_count  = 0;
  int                         cycle_count = 0;
  int                         seed        = 90283;
  string                      cur_name    = "reset";
  logic                       hold_valid  = 1'b0;
  noc_bridge_pkg::axis_data_t hold_data;
  noc_bridge_pkg::axis_strb_t hold_strb;
  noc_bridge_pkg::link_id_t   hold_dest;
  int                         mon_stream;
  noc_bridge_pkg::axis_data_t mon_exp;

  noc_axis_link_top #(
    .NumLinks (NumLinks)
  ) UUT (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .*
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic noc_bridge_pkg::chan_hdr_t header_for(int chan);
    if (chan == KindReq) return noc_bridge_pkg::HdrNarrowReq;
    if (chan == KindRsp) return noc_bridge_pkg::HdrNarrowRsp;
    return noc_bridge_pkg::HdrWide;
  endfunction

  // Narrow flits are zero-extended to the full payload
  function automatic noc_bridge_pkg::axis_data_t expect_word(noc_bridge_pkg::wide_data_t d,
                                                             int chan);
    noc_bridge_pkg::wide_data_t payload;
    payload = (chan == KindWide) ? d : noc_bridge_pkg::wide_data_t'(d[31:0]);
    return {payload, header_for(chan)};
  endfunction

  function automatic int queued_words();
    int total;
    total = 0;
    for (int s = 0; s < NumStreams; s++) begin
      total += exp_q[s].size();
    end
    return total;
  endfunction

  task automatic check_axis(noc_bridge_pkg::axis_data_t exp_data,
                            noc_bridge_pkg::axis_strb_t exp_strb,
                            noc_bridge_pkg::link_id_t exp_dest);
    if (axis_out_data_o !== exp_data || axis_out_strb_o !== exp_strb ||
        axis_out_dest_o !== exp_dest) begin
      abort_run($sformatf("FAILED %s: expected data %h strb %h dest %0d, actual %h %h %0d",
          cur_name, exp_data, exp_strb, exp_dest, axis_out_data_o, axis_out_strb_o,
          axis_out_dest_o));
    end
  endtask

  task automatic check_flit(noc_bridge_pkg::wide_data_t exp_flit,
                            noc_bridge_pkg::wide_data_t act_flit);
    if (act_flit !== exp_flit) begin
      abort_run($sformatf("FAILED %s: expected flit %h, actual flit %h",
          cur_name, exp_flit, act_flit));
    end
  endtask

  task automatic drive_stream(int s);
    int  link;
    bit  vld;
    link = s / 3;
    vld  = (pending[s] != 0);
    case (s % 3)
      KindReq: begin
        narrow_req_valid_i[link] = vld;
        narrow_req_data_i[link]  = cur_data[s][31:0];
      end
      KindRsp: begin
        narrow_rsp_valid_i[link] = vld;
        narrow_rsp_data_i[link]  = cur_data[s][31:0];
      end
      default: begin
        wide_valid_i[link] = vld;
        wide_data_i[link]  = cur_data[s];
      end
    endcase
  endtask

  function automatic logic stream_ready(int s);
    if (s % 3 == KindReq) return narrow_req_ready_o[s / 3];
    if (s % 3 == KindRsp) return narrow_rsp_ready_o[s / 3];
    return wide_ready_o[s / 3];
  endfunction

  task automatic set_port_ready(int link, int chan, logic value);
    case (chan)
      KindReq: narrow_req_ready_i[link] = value;
      KindRsp: narrow_rsp_ready_i[link] = value;
      default: wide_ready_i[link] = value;
    endcase
  endtask

  // Offers every pending stream word and records accepted ones as expected
  task automatic offer_flits(bit stall);
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      axis_out_ready_i = stall ? 1'($random(seed)) : 1'b1;
      for (int s = 0; s < NumStreams; s++) begin
        drive_stream(s);
      end
      @(posedge clk);
      busy = 1'b0;
      for (int s = 0; s < NumStreams; s++) begin
        if (pending[s] != 0 && stream_ready(s)) begin
          exp_q[s].push_back(expect_word(cur_data[s], s % 3));
          sent_count++;
          pending[s]--;
          cur_data[s] = {$random(seed), $random(seed)};
        end
        if (pending[s] != 0) begin
          busy = 1'b1;
        end
      end
    end
    @(negedge clk);
    for (int s = 0; s < NumStreams; s++) begin
      drive_stream(s);
    end
  endtask

  task automatic drain_output(bit stall);
    while (queued_words() != 0) begin
      @(negedge clk);
      axis_out_ready_i = stall ? 1'($random(seed)) : 1'b1;
    end
    @(negedge clk);
    axis_out_ready_i = 1'b1;
  endtask

  task automatic send_axis_in(int link, int chan, noc_bridge_pkg::wide_data_t data, bit stall);
    noc_bridge_pkg::wide_data_t exp_flit;
    noc_bridge_pkg::wide_data_t act_flit;
    logic [NumLinks-1:0]        target;
    int                         waited;
    bit                         done;
    exp_flit = (chan == KindWide) ? data : noc_bridge_pkg::wide_data_t'(data[31:0]);
    target   = NumLinks'(1) << link;
    waited   = 0;
    done     = 1'b0;
    @(negedge clk);
    axis_in_valid_i = 1'b1;
    axis_in_data_i  = {data, header_for(chan)};
    axis_in_dest_i  = noc_bridge_pkg::link_id_t'(link);
    if (stall) begin
      set_port_ready(link, chan, 1'b0);
    end
    while (!done) begin
      @(posedge clk);
      if (narrow_req_valid_o !== (chan == KindReq ? target : '0) ||
          narrow_rsp_valid_o !== (chan == KindRsp ? target : '0) ||
          wide_valid_o !== (chan == KindWide ? target : '0)) begin
        abort_run($sformatf("%s: a NoC output valid other than the addressed port", cur_name));
      end
      if (stall && waited < StallLen) begin
        if (axis_in_ready_o) begin
          abort_run($sformatf("%s: AXIS input ready high while the port stalled", cur_name));
        end
      end else if (axis_in_ready_o) begin
        case (chan)
          KindReq: act_flit = noc_bridge_pkg::wide_data_t'(narrow_req_data_o[link]);
          KindRsp: act_flit = noc_bridge_pkg::wide_data_t'(narrow_rsp_data_o[link]);
          default: act_flit = wide_data_o[link];
        endcase
        check_flit(exp_flit, act_flit);
        done = 1'b1;
      end else begin
        abort_run($sformatf("%s: AXIS input ready low with the port ready", cur_name));
      end
      waited++;
      @(negedge clk);
      if (waited == StallLen) begin
        set_port_ready(link, chan, 1'b1);
      end
    end
    axis_in_valid_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Output monitor and timeout
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (arst_n) begin
      // A stalled word must stay put
      if (hold_valid) begin
        if (!axis_out_valid_o) begin
          abort_run($sformatf("%s: AXIS output dropped valid while stalled", cur_name));
        end
        check_axis(hold_data, hold_strb, hold_dest);
      end
      if (axis_out_valid_o && axis_out_ready_i) begin
        mon_stream = 3 * int'(axis_out_dest_o) + int'(axis_out_data_o[1:0]);
        if (axis_out_data_o[1:0] == 2'd3 || exp_q[mon_stream].size() == 0) begin
          abort_run($sformatf("%s: AXIS output carried a word nobody sent", cur_name));
        end
        mon_exp = exp_q[mon_stream].pop_front();
        check_axis(mon_exp,
                   (mon_stream % 3 == KindWide) ? noc_bridge_pkg::WideStrb :
                                                  noc_bridge_pkg::NarrowStrb,
                   noc_bridge_pkg::link_id_t'(mon_stream / 3));
        recv_count++;
      end
      hold_valid = axis_out_valid_o & ~axis_out_ready_i;
      hold_data  = axis_out_data_o;
      hold_strb  = axis_out_strb_o;
      hold_dest  = axis_out_dest_o;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CycleLimit) begin
      abort_run("Timeout: the run went past its cycle limit before all words arrived");
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    clk                = 1'b0;
    arst_n             = 1'b0;
    narrow_req_valid_i = '0;
    narrow_rsp_valid_i = '0;
    wide_valid_i       = '0;
    narrow_req_data_i  = '0;
    narrow_rsp_data_i  = '0;
    wide_data_i        = '0;
    narrow_req_ready_i = '1;
    narrow_rsp_ready_i = '1;
    wide_ready_i       = '1;
    axis_out_ready_i   = 1'b1;
    axis_in_valid_i    = 1'b0;
    axis_in_data_i     = '0;
    axis_in_dest_i     = '0;
    for (int s = 0; s < NumStreams; s++) begin
      pending[s]  = 0;
      cur_data[s] = '0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    if (axis_out_valid_o || narrow_req_valid_o != '0 || narrow_rsp_valid_o != '0 ||
        wide_valid_o != '0 || narrow_req_ready_o != '0 || narrow_rsp_ready_o != '0 ||
        wide_ready_o != '0) begin
      abort_run("Valid or flit ready outputs were not low after reset");
    end

    for (int r = 0; r < NumRows; r++) begin
      cur_name = row_name[r];
      if (row_kind[r] >= KindInReq && row_kind[r] <= KindInWide) begin
        send_axis_in(row_link[r], row_kind[r] - KindInReq, row_data[r], row_stall[r]);
      end else begin
        if (row_kind[r] == KindBurst) begin
          for (int s = 0; s < NumStreams; s++) begin
            pending[s]  = BurstLen;
            cur_data[s] = {$random(seed), $random(seed)};
          end
        end else begin
          pending[3 * row_link[r] + row_kind[r]]  = 1;
          cur_data[3 * row_link[r] + row_kind[r]] = row_data[r];
        end
        offer_flits(row_stall[r]);
        drain_output(row_stall[r]);
      end
    end

    @(negedge clk);
    if (sent_count == recv_count && queued_words() == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      abort_run("Word count mismatch between flits sent and AXIS words received");
    end
  end

endmodule

// File: source/axis_lane_if.sv
// One internal stream lane with valid/ready handshake between splitter, bridges and merger

`timescale 1ns/10ps

interface axis_lane_if;

  logic                       tvalid;
  noc_bridge_pkg::axis_data_t tdata;
  noc_bridge_pkg::axis_strb_t tstrb;
  logic                       tready;

  // Producer side of the lane
  modport source (
    output tvalid,
    output tdata,
    output tstrb,
    input  tready
  );

  // Consumer side of the lane
  modport sink (
    input  tvalid,
    input  tdata,
    input  tstrb,
    output tready
  );

endinterface

// File: source/axis_link_merge.sv
// Round-robin merge of the bridge lanes onto one stream, tagging each word with its link

`timescale 1ns/10ps

module axis_link_merge #(
  parameter int unsigned NumLinks = 4
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // One lane per bridge
  axis_lane_if.sink                  lanes [NumLinks],
  // Outgoing stream
  output logic                       axis_valid_o,
  output noc_bridge_pkg::axis_data_t axis_data_o,
  output noc_bridge_pkg::axis_strb_t axis_strb_o,
  output noc_bridge_pkg::link_id_t   axis_dest_o,
  input  logic                       axis_ready_i
);

  logic [NumLinks-1:0]        lane_valid;
  noc_bridge_pkg::axis_data_t lane_data [NumLinks];
  noc_bridge_pkg::axis_strb_t lane_strb [NumLinks];
  logic [NumLinks-1:0]        grant;

  noc_bridge_pkg::link_id_t   rr_q;
  noc_bridge_pkg::link_id_t   win_idx;
  logic                       win_found;
  logic                       load;

  for (genvar i = 0; i < NumLinks; i++) begin : gen_lane
    assign lane_valid[i]  = lanes[i].tvalid;
    assign lane_data[i]   = lanes[i].tdata;
    assign lane_strb[i]   = lanes[i].tstrb;
    assign lanes[i].tready = grant[i];
  end

  // First valid lane at or after the pointer
  always_comb begin
    int unsigned idx;
    win_idx   = '0;
    win_found = 1'b0;
    for (int unsigned k = 0; k < NumLinks; k++) begin
      idx = (int'(rr_q) + k) % NumLinks;
      if (!win_found && lane_valid[idx]) begin
        win_found = 1'b1;
        win_idx   = noc_bridge_pkg::link_id_t'(idx);
      end
    end
  end

  // Register takes a new word when empty or draining this cycle
  assign load = ~axis_valid_o | axis_ready_i;

  for (genvar i = 0; i < NumLinks; i++) begin : gen_grant
    assign grant[i] = load & win_found & (win_idx == noc_bridge_pkg::link_id_t'(i));
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      axis_valid_o <= 1'b0;
      rr_q         <= '0;
    end else if (load) begin
      axis_valid_o <= win_found;
      if (win_found) begin
        rr_q <= (32'(win_idx) == NumLinks - 1) ? '0 : win_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load && win_found) begin
      axis_data_o <= lane_data[win_idx];
      axis_strb_o <= lane_strb[win_idx];
      axis_dest_o <= win_idx;
    end
  end

  // At most one bridge gives up its word per cycle
  one_grant_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(grant));

endmodule

// File: source/axis_link_split.sv
// Steers the incoming stream word to the bridge lane named by its destination

`timescale 1ns/10ps

module axis_link_split #(
  parameter int unsigned NumLinks = 4
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // Incoming stream
  input  logic                       axis_valid_i,
  input  noc_bridge_pkg::axis_data_t axis_data_i,
  input  noc_bridge_pkg::link_id_t   axis_dest_i,
  output logic                       axis_ready_o,
  // One lane per bridge
  axis_lane_if.source                lanes [NumLinks]
);

  logic [NumLinks-1:0] lane_ready;
  logic                wide_word;

  // Strobe rebuilt from the header, the input strobe is not carried
  assign wide_word = (axis_data_i[1:0] == noc_bridge_pkg::HdrWide);

  for (genvar i = 0; i < NumLinks; i++) begin : gen_lane
    assign lanes[i].tvalid = axis_valid_i &
                             (axis_dest_i == noc_bridge_pkg::link_id_t'(i));
    assign lanes[i].tdata  = axis_data_i;
    assign lanes[i].tstrb  = wide_word ? noc_bridge_pkg::WideStrb : noc_bridge_pkg::NarrowStrb;
    assign lane_ready[i]   = lanes[i].tready;
  end

  // Ready comes back from the addressed lane only
  always_comb begin
    axis_ready_o = 1'b0;
    for (int unsigned i = 0; i < NumLinks; i++) begin
      if (axis_dest_i == noc_bridge_pkg::link_id_t'(i)) begin
        axis_ready_o = lane_ready[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Destination must name an existing link, else the word would hang
  dest_in_range_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      axis_valid_i |-> 32'(axis_dest_i) < NumLinks);

endmodule

// File: source/noc_axis_bridge.sv
// Per-link bridge that packs three NoC flit channels onto one stream lane and back

`timescale 1ns/10ps

module noc_axis_bridge (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  // Flits from the NoC
  input  logic                         narrow_req_valid_i,
  input  noc_bridge_pkg::narrow_data_t narrow_req_data_i,
  output logic                         narrow_req_ready_o,
  input  logic                         narrow_rsp_valid_i,
  input  noc_bridge_pkg::narrow_data_t narrow_rsp_data_i,
  output logic                         narrow_rsp_ready_o,
  input  logic                         wide_valid_i,
  input  noc_bridge_pkg::wide_data_t   wide_data_i,
  output logic                         wide_ready_o,
  // Flits to the NoC
  output logic                         narrow_req_valid_o,
  output noc_bridge_pkg::narrow_data_t narrow_req_data_o,
  input  logic                         narrow_req_ready_i,
  output logic                         narrow_rsp_valid_o,
  output noc_bridge_pkg::narrow_data_t narrow_rsp_data_o,
  input  logic                         narrow_rsp_ready_i,
  output logic                         wide_valid_o,
  output noc_bridge_pkg::wide_data_t   wide_data_o,
  input  logic                         wide_ready_i,
  // Stream lanes
  axis_lane_if.source                  lane_out,
  axis_lane_if.sink                    lane_in
);

  // High means the response channel has priority
  logic                       rr_q;
  logic                       grant_req, grant_rsp;
  logic                       arb_valid, arb_ready;
  noc_bridge_pkg::axis_data_t arb_data;

  noc_bridge_pkg::sel_chan_e  sel_q, sel_d;

  logic                       fifo_in_valid, fifo_in_ready;
  noc_bridge_pkg::axis_data_t fifo_in_data;
  noc_bridge_pkg::axis_data_t fifo_mem [2];
  logic                       wr_ptr_q, rd_ptr_q;
  logic [1:0]                 count_q;
  logic                       push, pop;

  noc_bridge_pkg::chan_hdr_t  out_hdr, in_hdr;

  //////////////////////////////////////////////////
  // Outgoing side
  //////////////////////////////////////////////////

  // Two-way round robin between the narrow channels
  assign arb_valid = narrow_req_valid_i | narrow_rsp_valid_i;
  assign grant_req = narrow_req_valid_i & (~narrow_rsp_valid_i | ~rr_q);
  assign grant_rsp = narrow_rsp_valid_i & ~grant_req;

  assign arb_data = grant_req ?
      {noc_bridge_pkg::wide_data_t'(narrow_req_data_i), noc_bridge_pkg::HdrNarrowReq} :
      {noc_bridge_pkg::wide_data_t'(narrow_rsp_data_i), noc_bridge_pkg::HdrNarrowRsp};

  assign narrow_req_ready_o = arb_ready & grant_req;
  assign narrow_rsp_ready_o = arb_ready & grant_rsp;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q <= 1'b0;
    end else if (arb_valid && arb_ready) begin
      rr_q <= grant_req;
    end
  end

  // Wide channel only gets the FIFO while no narrow flit waits
  always_comb begin
    sel_d         = sel_q;
    fifo_in_valid = 1'b0;
    fifo_in_data  = arb_data;
    arb_ready     = 1'b0;
    wide_ready_o  = 1'b0;
    unique case (sel_q)
      noc_bridge_pkg::SelNarrow: begin
        fifo_in_valid = arb_valid;
        arb_ready     = fifo_in_ready;
        if (wide_valid_i && !arb_valid) begin
          sel_d = noc_bridge_pkg::SelWide;
        end
      end
      noc_bridge_pkg::SelWide: begin
        fifo_in_data  = {wide_data_i, noc_bridge_pkg::HdrWide};
        fifo_in_valid = wide_valid_i;
        wide_ready_o  = fifo_in_ready;
        // Back to narrow once wide is idle or has just moved a flit
        if ((!wide_valid_i || fifo_in_ready) && arb_valid) begin
          sel_d = noc_bridge_pkg::SelNarrow;
        end
      end
      default: sel_d = noc_bridge_pkg::SelNarrow;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q <= noc_bridge_pkg::SelNarrow;
    end else begin
      sel_q <= sel_d;
    end
  end

  // Two-entry FIFO towards the merger
  assign fifo_in_ready = (count_q != 2'd2);
  assign push          = fifo_in_valid & fifo_in_ready;
  assign pop           = lane_out.tvalid & lane_out.tready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q  <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= fifo_in_data;
    end
  end

  assign lane_out.tvalid = (count_q != 2'd0);
  assign lane_out.tdata  = fifo_mem[rd_ptr_q];
  assign out_hdr         = lane_out.tdata[1:0];
  assign lane_out.tstrb  = (out_hdr == noc_bridge_pkg::HdrWide) ?
                           noc_bridge_pkg::WideStrb : noc_bridge_pkg::NarrowStrb;

  //////////////////////////////////////////////////
  // Incoming side
  //////////////////////////////////////////////////

  assign in_hdr = lane_in.tdata[1:0];

  assign narrow_req_valid_o = lane_in.tvalid & (in_hdr == noc_bridge_pkg::HdrNarrowReq);
  assign narrow_rsp_valid_o = lane_in.tvalid & (in_hdr == noc_bridge_pkg::HdrNarrowRsp);
  assign wide_valid_o       = lane_in.tvalid & (in_hdr == noc_bridge_pkg::HdrWide);

  assign narrow_req_data_o = lane_in.tdata[noc_bridge_pkg::NarrowDataW+1:2];
  assign narrow_rsp_data_o = lane_in.tdata[noc_bridge_pkg::NarrowDataW+1:2];
  assign wide_data_o       = lane_in.tdata[noc_bridge_pkg::WideDataW+1:2];

  // Lane ready follows whichever port the header selects
  always_comb begin
    case (in_hdr)
      noc_bridge_pkg::HdrNarrowReq: lane_in.tready = narrow_req_ready_i;
      noc_bridge_pkg::HdrNarrowRsp: lane_in.tready = narrow_rsp_ready_i;
      noc_bridge_pkg::HdrWide:      lane_in.tready = wide_ready_i;
      default:                      lane_in.tready = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Stalled word must wait unchanged for the merger
  lane_out_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      lane_out.tvalid && !lane_out.tready |=>
      lane_out.tvalid && $stable(lane_out.tdata) && $stable(lane_out.tstrb));

  // Reserved header never arrives from the link
  lane_in_hdr_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      lane_in.tvalid |-> lane_in.tdata[1:0] != 2'd3);

endmodule

// File: source/noc_axis_link_top.sv
// Top level joining NumLinks NoC bridges to one shared AXIS channel through split and merge

`timescale 1ns/10ps

module noc_axis_link_top #(
  parameter int unsigned NumLinks = 4
) (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  //////////////////////////////////////////////////
  // NoC side, one entry per link
  //////////////////////////////////////////////////
  input  logic [NumLinks-1:0]                         narrow_req_valid_i,
  input  noc_bridge_pkg::narrow_data_t [NumLinks-1:0] narrow_req_data_i,
  output logic [NumLinks-1:0]                         narrow_req_ready_o,
  input  logic [NumLinks-1:0]                         narrow_rsp_valid_i,
  input  noc_bridge_pkg::narrow_data_t [NumLinks-1:0] narrow_rsp_data_i,
  output logic [NumLinks-1:0]                         narrow_rsp_ready_o,
  input  logic [NumLinks-1:0]                         wide_valid_i,
  input  noc_bridge_pkg::wide_data_t [NumLinks-1:0]   wide_data_i,
  output logic [NumLinks-1:0]                         wide_ready_o,
  output logic [NumLinks-1:0]                         narrow_req_valid_o,
  output noc_bridge_pkg::narrow_data_t [NumLinks-1:0] narrow_req_data_o,
  input  logic [NumLinks-1:0]                         narrow_req_ready_i,
  output logic [NumLinks-1:0]                         narrow_rsp_valid_o,
  output noc_bridge_pkg::narrow_data_t [NumLinks-1:0] narrow_rsp_data_o,
  input  logic [NumLinks-1:0]                         narrow_rsp_ready_i,
  output logic [NumLinks-1:0]                         wide_valid_o,
  output noc_bridge_pkg::wide_data_t [NumLinks-1:0]   wide_data_o,
  input  logic [NumLinks-1:0]                         wide_ready_i,
  //////////////////////////////////////////////////
  // Shared AXIS channel
  //////////////////////////////////////////////////
  output logic                                        axis_out_valid_o,
  output noc_bridge_pkg::axis_data_t                  axis_out_data_o,
  output noc_bridge_pkg::axis_strb_t                  axis_out_strb_o,
  output noc_bridge_pkg::link_id_t                    axis_out_dest_o,
  input  logic                                        axis_out_ready_i,
  input  logic                                        axis_in_valid_i,
  input  noc_bridge_pkg::axis_data_t                  axis_in_data_i,
  input  noc_bridge_pkg::link_id_t                    axis_in_dest_i,
  output logic                                        axis_in_ready_o
);

  // Bridge to merger
  axis_lane_if out_lane [NumLinks] ();
  // Splitter to bridge
  axis_lane_if in_lane [NumLinks] ();

  axis_link_split #(
    .NumLinks (NumLinks)
  ) u_split (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .axis_valid_i (axis_in_valid_i),
    .axis_data_i  (axis_in_data_i),
    .axis_dest_i  (axis_in_dest_i),
    .axis_ready_o (axis_in_ready_o),
    .lanes        (in_lane)
  );

  for (genvar i = 0; i < NumLinks; i++) begin : gen_bridge
    noc_axis_bridge u_bridge (
      .clk_i              (clk_i),
      .arst_n_i           (arst_n_i),
      .narrow_req_valid_i (narrow_req_valid_i[i]),
      .narrow_req_data_i  (narrow_req_data_i[i]),
      .narrow_req_ready_o (narrow_req_ready_o[i]),
      .narrow_rsp_valid_i (narrow_rsp_valid_i[i]),
      .narrow_rsp_data_i  (narrow_rsp_data_i[i]),
      .narrow_rsp_ready_o (narrow_rsp_ready_o[i]),
      .wide_valid_i       (wide_valid_i[i]),
      .wide_data_i        (wide_data_i[i]),
      .wide_ready_o       (wide_ready_o[i]),
      .narrow_req_valid_o (narrow_req_valid_o[i]),
      .narrow_req_data_o  (narrow_req_data_o[i]),
      .narrow_req_ready_i (narrow_req_ready_i[i]),
      .narrow_rsp_valid_o (narrow_rsp_valid_o[i]),
      .narrow_rsp_data_o  (narrow_rsp_data_o[i]),
      .narrow_rsp_ready_i (narrow_rsp_ready_i[i]),
      .wide_valid_o       (wide_valid_o[i]),
      .wide_data_o        (wide_data_o[i]),
      .wide_ready_i       (wide_ready_i[i]),
      .lane_out           (out_lane[i]),
      .lane_in            (in_lane[i])
    );
  end

  axis_link_merge #(
    .NumLinks (NumLinks)
  ) u_merge (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .lanes        (out_lane),
    .axis_valid_o (axis_out_valid_o),
    .axis_data_o  (axis_out_data_o),
    .axis_strb_o  (axis_out_strb_o),
    .axis_dest_o  (axis_out_dest_o),
    .axis_ready_i (axis_out_ready_i)
  );

endmodule

// File: source/noc_bridge_pkg.sv
// Shared widths, channel header codes, strobes and types for the NoC to AXIS bridge

package noc_bridge_pkg;

  //////////////////////////////////////////////////
  // Data widths
  //////////////////////////////////////////////////

  localparam int unsigned NarrowDataW = 32;
  localparam int unsigned WideDataW   = 64;

  typedef logic [NarrowDataW-1:0] narrow_data_t;
  typedef logic [WideDataW-1:0]   wide_data_t;

  //////////////////////////////////////////////////
  // Channel header
  //////////////////////////////////////////////////

  typedef logic [1:0] chan_hdr_t;

  localparam chan_hdr_t HdrNarrowReq = 2'd0;
  localparam chan_hdr_t HdrNarrowRsp = 2'd1;
  localparam chan_hdr_t HdrWide      = 2'd2;
  // Code 3 is reserved

  // Flit data on top, header in the two low bits
  typedef logic [WideDataW+1:0] axis_data_t;

  typedef logic [WideDataW/8-1:0] axis_strb_t;

  localparam axis_strb_t NarrowStrb = 8'h0F;
  localparam axis_strb_t WideStrb   = 8'hFF;

  //////////////////////////////////////////////////
  // Links and bridge state
  //////////////////////////////////////////////////

  localparam int unsigned MaxLinks = 4;

  typedef logic [1:0] link_id_t;

  typedef enum logic {
    SelNarrow,
    SelWide
  } sel_chan_e;

endpackage
